// File: soc_top.f
+incdir+.
soc_pkg.sv
rst_sequencer.sv
bus_decoder.sv
devtbl_regs.sv
intr_ctrl.sv
scratch_ram.sv
soc_top.sv
tb_soc_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SoC fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	--top-module tb_soc_top \
	-f soc_top.f \
	-o sim_tb_soc_top

out=$(./obj_dir/sim_tb_soc_top)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
	exit 0
else
	exit 1
fi

// File: tb_soc_top.sv
/*
 * Testbench for the SoC fabric. Plays the Wishbone master with
 * random stimulus and checks against its own model
 */
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module tb_soc_top;

	localparam int RAM_WIN    = 64;
	localparam int RAM_OPS    = 200;
	localparam int INV_OPS    = 40;
	localparam int INT_ROUNDS = 20;
	localparam int OFF_HOLD   = 40;
	localparam int MAP_END    = `INTCTRL_BASE + `INTCTRL_WORDS;
	// Transfers take three cycles each
	localparam int XFERS      = RAM_WIN + 2 * RAM_OPS + `DEVTBL_WORDS + INV_OPS + RAM_WIN
		+ INT_ROUNDS * 6 + 3 * (RAM_WIN + 2);
	localparam int LIMIT_CYCLES = 2 * (3 * XFERS + 8 * `RST_CYCLES + OFF_HOLD + 4 * INT_ROUNDS);

	logic                       clk;
	logic                       rst_p;
	logic                       wb_cyc;
	logic                       wb_stb;
	logic                       wb_we;
	logic [`ADDR_W-1:0]         wb_adr;
	logic [`DATA_W-1:0]         wb_dat;
	logic [`SEL_W-1:0]          wb_sel;
	logic [`DATA_W-1:0]         wb_dat_o;
	logic                       wb_ack_o;
	logic [`INTR_SRC_COUNT-1:0] intr_src;
	logic                       intr_rqst_o;
	logic                       sys_rst_o;

	logic [`DATA_W-1:0]         ram_model [RAM_WIN];
	logic [`INTR_SRC_COUNT-1:0] pending_model;
	int errors       = 0;
	int checks       = 0;
	int tests_run    = 0;
	int tests_failed = 0;
	int cycles       = 0;

	soc_top i_dut (
		.clk48mhz_i  (clk),
		.rst_p       (rst_p),
		.wb_cyc_i    (wb_cyc),
		.wb_stb_i    (wb_stb),
		.wb_we_i     (wb_we),
		.wb_adr_i    (wb_adr),
		.wb_dat_i    (wb_dat),
		.wb_sel_i    (wb_sel),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.intr_src_i  (intr_src),
		.intr_rqst_o (intr_rqst_o),
		.sys_rst_o   (sys_rst_o)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= LIMIT_CYCLES) begin
			$display("Timeout: the run was still going after %0d cycles", cycles);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic check_eq(input logic [`DATA_W-1:0] got, input logic [`DATA_W-1:0] exp,
			input string msg);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t ns %s: got %h, expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int err_start);
		tests_run++;
		if (errors == err_start) begin
			$display("Test %s: passed", name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err_start);
		end
	endtask

	// One classic cycle, ack expected on the second negedge
	task automatic bus_xfer(input logic we, input logic [`ADDR_W-1:0] adr,
			input logic [`DATA_W-1:0] dat, input logic [`SEL_W-1:0] sel,
			output logic [`DATA_W-1:0] rdat);
		int waits;
		@(posedge clk);
		wb_cyc <= 1'b1;
		wb_stb <= 1'b1;
		wb_we  <= we;
		wb_adr <= adr;
		wb_dat <= dat;
		wb_sel <= sel;
		waits = 0;
		@(negedge clk);
		while (!wb_ack_o && waits < 8) begin
			waits++;
			@(negedge clk);
		end
		rdat = wb_dat_o;
		if (!wb_ack_o) begin
			errors++;
			$display("Bus transfer to address %h was never acknowledged", adr);
		end else begin
			check_eq(32'(waits), 32'd1, "ack one cycle after request");
		end
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
	endtask

	task automatic bus_write(input logic [`ADDR_W-1:0] adr, input logic [`DATA_W-1:0] dat,
			input logic [`SEL_W-1:0] sel);
		logic [`DATA_W-1:0] unused;
		bus_xfer(1'b1, adr, dat, sel, unused);
	endtask

	task automatic bus_read(input logic [`ADDR_W-1:0] adr, output logic [`DATA_W-1:0] rdat);
		bus_xfer(1'b0, adr, '0, '1, rdat);
	endtask

	// Called right after the edge that starts the count
	task automatic measure_reset(output int len);
		len = 0;
		@(negedge clk);
		while (sys_rst_o && len < 4 * `RST_CYCLES) begin
			check_eq(32'(wb_ack_o), 32'd0, "ack low during reset");
			len++;
			@(posedge clk);
			// Read request stays up through the count
			wb_cyc <= 1'b1;
			wb_stb <= 1'b1;
			wb_we  <= 1'b0;
			@(negedge clk);
		end
		@(posedge clk);
		@(negedge clk);
		check_eq(32'(wb_ack_o), 32'd1, "held request acked after reset");
		@(posedge clk);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
	endtask

	function automatic logic [`DATA_W-1:0] fill_word(input logic [`ADDR_W-1:0] adr);
		return 32'h5A3C_0000 ^ {2'b00, adr} ^ ({2'b00, adr} << 16);
	endfunction

	function automatic logic [`DATA_W-1:0] table_word(input int w);
		logic [`DATA_W-1:0] ids [4];
		logic [`DATA_W-1:0] sizes [4];
		ids[0]   = `DATA_W'(`ID_RAM);
		ids[1]   = `DATA_W'(`ID_DEVTBL);
		ids[2]   = `DATA_W'(`ID_INTCTRL) | 32'h8000_0000;
		ids[3]   = `DATA_W'(`ID_INVALID);
		sizes[0] = `DATA_W'(`RAM_WORDS);
		sizes[1] = `DATA_W'(`DEVTBL_WORDS);
		sizes[2] = `DATA_W'(`INTCTRL_WORDS);
		sizes[3] = `DATA_W'(`INVALID_WORDS);
		if (w == 0) begin
			return `DATA_W'(`SOC_ID);
		end else if (w == 1) begin
			return `DATA_W'(4);
		end else if (w >= 2 && w <= 9) begin
			return (w % 2 == 0) ? ids[(w - 2) / 2] : sizes[(w - 2) / 2];
		end
		return '0;
	endfunction

	function automatic logic [`DATA_W-1:0] lowest_pending(input logic [`INTR_SRC_COUNT-1:0] p);
		for (int i = 0; i < `INTR_SRC_COUNT; i++) begin
			if (p[i]) begin
				return `DATA_W'(i);
			end
		end
		return '1;
	endfunction

	task automatic check_ram_window(input string what);
		logic [`DATA_W-1:0] rdat;
		for (int a = 0; a < RAM_WIN; a++) begin
			bus_read(`ADDR_W'(`RAM_BASE + a), rdat);
			check_eq(rdat, ram_model[a], what);
		end
	endtask

	// Source high for exactly one sampled edge
	task automatic pulse_sources(input logic [`INTR_SRC_COUNT-1:0] pattern);
		@(posedge clk);
		intr_src <= pattern;
		@(posedge clk);
		intr_src <= '0;
		pending_model = pending_model | pattern;
		@(negedge clk);
		check_eq(32'(intr_rqst_o), 32'(|pending_model), "request after source pulse");
	endtask

	task automatic drain_interrupts();
		logic [`DATA_W-1:0] rdat;
		logic [`DATA_W-1:0] exp;
		for (int n = 0; n <= `INTR_SRC_COUNT; n++) begin
			exp = lowest_pending(pending_model);
			bus_read(`ADDR_W'(`INTCTRL_BASE), rdat);
			check_eq(rdat, exp, "claim index");
			if (exp == '1) begin
				break;
			end
			bus_write(`ADDR_W'(`INTCTRL_BASE), exp, '1);
			pending_model = pending_model & ~(`INTR_SRC_COUNT'(1) << exp);
			@(negedge clk);
			check_eq(32'(intr_rqst_o), 32'(|pending_model), "request after clear");
		end
	endtask

	task automatic soft_reset(input logic [1:0] code, input string name);
		int                 len;
		logic [`DATA_W-1:0] rdat;
		pulse_sources('1);
		bus_write(`ADDR_W'(`DEVTBL_BASE + 15), `DATA_W'(code), 4'b0001);
		measure_reset(len);
		check_eq(32'(len), 32'(`RST_CYCLES), {name, " reset length"});
		pending_model = '0;
		check_eq(32'(intr_rqst_o), 32'd0, {name, " reset drops request"});
		bus_read(`ADDR_W'(`INTCTRL_BASE), rdat);
		check_eq(rdat, '1, {name, " reset clears pending"});
		check_ram_window({name, " reset keeps RAM"});
	endtask

	task automatic power_off();
		int held;
		int len;
		held = 0;
		bus_write(`ADDR_W'(`DEVTBL_BASE + 15), `DATA_W'(2'b01), 4'b0001);
		repeat (OFF_HOLD) begin
			@(negedge clk);
			if (sys_rst_o) begin
				held++;
			end
		end
		check_eq(32'(held), 32'(OFF_HOLD), "power-off holds reset");
		// Only the button leaves power-off
		@(posedge clk);
		rst_p <= 1'b1;
		repeat (3) @(posedge clk);
		rst_p <= 1'b0;
		measure_reset(len);
		check_eq(32'(len), 32'(`RST_CYCLES), "reset length after power-off");
		check_ram_window("RAM after power-off");
	endtask

	initial begin
		logic [`DATA_W-1:0] rdat;
		logic [`DATA_W-1:0] dat;
		logic [`ADDR_W-1:0] adr;
		logic [`SEL_W-1:0]  sel;
		int                 seed_ret;
		int                 len;
		int                 idx;
		int                 err_start;
		seed_ret = $urandom(71091);
		rst_p    = 1'b1;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat   = '0;
		wb_sel   = '0;
		intr_src = '0;

		err_start = errors;
		repeat (10) @(posedge clk);
		rst_p <= 1'b0;
		measure_reset(len);
		check_eq(32'(len), 32'(`RST_CYCLES), "counted reset length");
		end_test("counted reset", err_start);

		err_start = errors;
		for (int a = 0; a < RAM_WIN; a++) begin
			ram_model[a] = fill_word(`ADDR_W'(`RAM_BASE + a));
			bus_write(`ADDR_W'(`RAM_BASE + a), ram_model[a], '1);
		end
		for (int i = 0; i < RAM_OPS; i++) begin
			idx = int'($urandom % RAM_WIN);
			dat = $urandom;
			sel = `SEL_W'($urandom);
			bus_write(`ADDR_W'(`RAM_BASE + idx), dat, sel);
			for (int b = 0; b < `SEL_W; b++) begin
				if (sel[b]) begin
					ram_model[idx][b*8 +: 8] = dat[b*8 +: 8];
				end
			end
			idx = int'($urandom % RAM_WIN);
			bus_read(`ADDR_W'(`RAM_BASE + idx), rdat);
			check_eq(rdat, ram_model[idx], "RAM read");
		end
		end_test("RAM", err_start);

		err_start = errors;
		for (int w = 0; w < `DEVTBL_WORDS; w++) begin
			bus_read(`ADDR_W'(`DEVTBL_BASE + w), rdat);
			check_eq(rdat, table_word(w), $sformatf("device table word %0d", w));
		end
		end_test("device table", err_start);

		// Half the addresses just above the map, half anywhere beyond it
		err_start = errors;
		for (int i = 0; i < INV_OPS; i++) begin
			if (i % 4 < 2) begin
				adr = `ADDR_W'(MAP_END + int'($urandom % 1024));
			end else begin
				adr = `ADDR_W'($urandom);
				if (adr < `ADDR_W'(MAP_END)) begin
					adr = adr + `ADDR_W'(MAP_END);
				end
			end
			if (i % 2 == 0) begin
				bus_read(adr, rdat);
				check_eq(rdat, '0, "invalid region read");
			end else begin
				bus_write(adr, $urandom, '1);
			end
		end
		check_ram_window("RAM after invalid writes");
		end_test("invalid region", err_start);

		err_start = errors;
		pending_model = '0;
		for (int r = 0; r < INT_ROUNDS; r++) begin
			pulse_sources(`INTR_SRC_COUNT'($urandom));
			if ($urandom % 3 == 0 || r == INT_ROUNDS - 1) begin
				drain_interrupts();
			end
		end
		bus_read(`ADDR_W'(`INTCTRL_BASE + 5), rdat);
		check_eq(rdat, '0, "interrupt controller spare word");
		end_test("interrupts", err_start);

		err_start = errors;
		soft_reset(2'b11, "cold");
		soft_reset(2'b10, "warm");
		power_off();
		end_test("software reset", err_start);

		$display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: soc_top.sv
/*
 * SoC fabric top level. Reset sequencer, address decoder and the
 * device table, interrupt controller and scratch RAM slaves
 */
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module soc_top (
	input  logic                       clk48mhz_i,
	input  logic                       rst_p,
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	input  logic                       wb_we_i,
	input  logic [`ADDR_W-1:0]         wb_adr_i,
	input  logic [`DATA_W-1:0]         wb_dat_i,
	input  logic [`SEL_W-1:0]          wb_sel_i,
	output logic [`DATA_W-1:0]         wb_dat_o,
	output logic                       wb_ack_o,
	input  logic [`INTR_SRC_COUNT-1:0] intr_src_i,
	output logic                       intr_rqst_o,
	output logic                       sys_rst_o
);

	soc_pkg::rst_cmd_e  rst_cmd;

	logic               ram_stb;
	logic [`DATA_W-1:0] ram_dat;
	logic               ram_ack;
	logic               devtbl_stb;
	logic [`DATA_W-1:0] devtbl_dat;
	logic               devtbl_ack;
	logic               intr_stb;
	logic [`DATA_W-1:0] intr_dat;
	logic               intr_ack;

	rst_sequencer i_rst_seq (
		.clk48mhz_i (clk48mhz_i),
		.rst_p      (rst_p),
		.rst_cmd_i  (rst_cmd),
		.sys_rst_o  (sys_rst_o)
	);

	bus_decoder i_decoder (
		.clk48mhz_i   (clk48mhz_i),
		.sys_rst_i    (sys_rst_o),
		.wb_cyc_i     (wb_cyc_i),
		.wb_stb_i     (wb_stb_i),
		.wb_adr_i     (wb_adr_i),
		.ram_stb_o    (ram_stb),
		.ram_dat_i    (ram_dat),
		.ram_ack_i    (ram_ack),
		.devtbl_stb_o (devtbl_stb),
		.devtbl_dat_i (devtbl_dat),
		.devtbl_ack_i (devtbl_ack),
		.intr_stb_o   (intr_stb),
		.intr_dat_i   (intr_dat),
		.intr_ack_i   (intr_ack),
		.wb_dat_o     (wb_dat_o),
		.wb_ack_o     (wb_ack_o)
	);

	// Region bases are aligned, so the low address bits are the offset
	devtbl_regs i_devtbl (
		.clk48mhz_i (clk48mhz_i),
		.sys_rst_i  (sys_rst_o),
		.stb_i      (devtbl_stb),
		.we_i       (wb_we_i),
		.adr_i      (wb_adr_i[3:0]),
		.dat_i      (wb_dat_i),
		.sel_i      (wb_sel_i),
		.dat_o      (devtbl_dat),
		.ack_o      (devtbl_ack),
		.rst_cmd_o  (rst_cmd)
	);

	intr_ctrl i_intr (
		.clk48mhz_i  (clk48mhz_i),
		.sys_rst_i   (sys_rst_o),
		.stb_i       (intr_stb),
		.we_i        (wb_we_i),
		.adr_i       (wb_adr_i[3:0]),
		.dat_i       (wb_dat_i),
		.dat_o       (intr_dat),
		.ack_o       (intr_ack),
		.intr_src_i  (intr_src_i),
		.intr_rqst_o (intr_rqst_o)
	);

	scratch_ram i_ram (
		.clk48mhz_i (clk48mhz_i),
		.sys_rst_i  (sys_rst_o),
		.stb_i      (ram_stb),
		.we_i       (wb_we_i),
		.adr_i      (wb_adr_i[9:0]),
		.dat_i      (wb_dat_i),
		.sel_i      (wb_sel_i),
		.dat_o      (ram_dat),
		.ack_o      (ram_ack)
	);

endmodule

`default_nettype wire

// File: scratch_ram.sv
/*
 * Scratch word RAM slave with byte-select writes
 */
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module scratch_ram (
	input  logic               clk48mhz_i,
	input  logic               sys_rst_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  logic [9:0]         adr_i,
	input  logic [`DATA_W-1:0] dat_i,
	input  logic [`SEL_W-1:0]  sel_i,
	output logic [`DATA_W-1:0] dat_o,
	output logic               ack_o
);

	logic [`DATA_W-1:0] mem [`RAM_WORDS];
	logic               ack_q;
	logic               access;

	assign access = stb_i & ~ack_q;

	// Contents survive a system reset
	always_ff @(posedge clk48mhz_i) begin
		if (access) begin
			if (we_i) begin
				for (int b = 0; b < `SEL_W; b++) begin
					if (sel_i[b]) begin
						mem[adr_i][b*8 +: 8] <= dat_i[b*8 +: 8];
					end
				end
			end
			dat_o <= mem[adr_i];
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	assign ack_o = ack_q;

endmodule

`default_nettype wire

// File: intr_ctrl.sv
/*
 * Interrupt controller. Latches pending sources, requests service
 * while any is pending, claim by read and clear by write of word 0
 */
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module intr_ctrl (
	input  logic                      clk48mhz_i,
	input  logic                      sys_rst_i,
	input  logic                      stb_i,
	input  logic                      we_i,
	input  logic [3:0]                adr_i,
	input  logic [`DATA_W-1:0]        dat_i,
	output logic [`DATA_W-1:0]        dat_o,
	output logic                      ack_o,
	input  logic [`INTR_SRC_COUNT-1:0] intr_src_i,
	output logic                      intr_rqst_o
);

	logic                       ack_q;
	logic                       access;
	logic                       clr_wr;
	logic [`INTR_SRC_COUNT-1:0] pending_q;
	logic [`INTR_SRC_COUNT-1:0] pending_nxt;
	logic [`DATA_W-1:0]         claim;

	assign access = stb_i & ~ack_q;
	assign clr_wr = access & we_i & (adr_i == 4'd0);

	// Lowest pending index, all ones when idle
	always_comb begin
		claim = '1;
		for (int i = `INTR_SRC_COUNT - 1; i >= 0; i--) begin
			if (pending_q[i]) begin
				claim = `DATA_W'(i);
			end
		end
	end

	always_comb begin
		pending_nxt = pending_q;
		if (clr_wr) begin
			for (int i = 0; i < `INTR_SRC_COUNT; i++) begin
				if (dat_i == `DATA_W'(i)) begin
					pending_nxt[i] = 1'b0;
				end
			end
		end
		// A new event beats a clear in the same cycle
		pending_nxt = pending_nxt | intr_src_i;
	end

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			ack_q     <= 1'b0;
			pending_q <= '0;
		end else begin
			ack_q     <= access;
			pending_q <= pending_nxt;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (access) begin
			dat_o <= (adr_i == 4'd0) ? claim : '0;
		end
	end

	assign ack_o       = ack_q;
	assign intr_rqst_o = |pending_q;

endmodule

`default_nettype wire

// File: devtbl_regs.sv
/*
 * Device table. Read-only SoC id and per-slot id/map size words,
 * plus the write-only software reset control register
 */
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module devtbl_regs (
	input  logic               clk48mhz_i,
	input  logic               sys_rst_i,
	input  logic               stb_i,
	input  logic               we_i,
	input  logic [3:0]         adr_i,
	input  logic [`DATA_W-1:0] dat_i,
	input  logic [`SEL_W-1:0]  sel_i,
	output logic [`DATA_W-1:0] dat_o,
	output logic               ack_o,
	output soc_pkg::rst_cmd_e  rst_cmd_o
);

	logic               ack_q;
	logic               access;
	logic [1:0]         rst_bits_q;
	logic [3:0]         ofs;
	soc_pkg::slot_e     tbl_slot;
	logic [`DATA_W-1:0] dev_id;
	logic [`DATA_W-1:0] map_sz;
	logic [`DATA_W-1:0] rd_word;

	assign access = stb_i & ~ack_q;

	// Slot entries start at word 2, two words each
	assign ofs      = adr_i - 4'd2;
	assign tbl_slot = soc_pkg::slot_e'(ofs[2:1]);

	always_comb begin
		dev_id = `DATA_W'(`ID_INVALID);
		map_sz = `DATA_W'(`INVALID_WORDS);
		case (tbl_slot)
			soc_pkg::SLOT_RAM: begin
				dev_id = `DATA_W'(`ID_RAM);
				map_sz = `DATA_W'(`RAM_WORDS);
			end
			soc_pkg::SLOT_DEVTBL: begin
				dev_id = `DATA_W'(`ID_DEVTBL);
				map_sz = `DATA_W'(`DEVTBL_WORDS);
			end
			soc_pkg::SLOT_INTCTRL: begin
				dev_id = `DATA_W'(`ID_INTCTRL);
				dev_id[`DATA_W-1] = 1'b1;   // uses interrupts
				map_sz = `DATA_W'(`INTCTRL_WORDS);
			end
			default: begin
				dev_id = `DATA_W'(`ID_INVALID);
				map_sz = `DATA_W'(`INVALID_WORDS);
			end
		endcase
	end

	always_comb begin
		if (adr_i == 4'd0) begin
			rd_word = `DATA_W'(`SOC_ID);
		end else if (adr_i == 4'd1) begin
			rd_word = `DATA_W'(2 ** $bits(soc_pkg::slot_e));
		end else if (adr_i <= 4'd9) begin
			rd_word = ofs[0] ? map_sz : dev_id;
		end else begin
			rd_word = '0;
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			ack_q      <= 1'b0;
			rst_bits_q <= 2'b00;
		end else begin
			ack_q <= access;
			if (access && we_i && sel_i[0] && adr_i == 4'd15) begin
				rst_bits_q <= dat_i[1:0];
			end
		end
	end

	always_ff @(posedge clk48mhz_i) begin
		if (access) begin
			dat_o <= rd_word;
		end
	end

	assign ack_o = ack_q;

	always_comb begin
		case (rst_bits_q)
			2'b11:   rst_cmd_o = soc_pkg::RST_COLD;
			2'b10:   rst_cmd_o = soc_pkg::RST_WARM;
			2'b01:   rst_cmd_o = soc_pkg::RST_OFF;
			default: rst_cmd_o = soc_pkg::RST_NONE;
		endcase
	end

endmodule

`default_nettype wire

// File: bus_decoder.sv
/*
 * Wishbone address decoder. Routes the strobe to one slave region,
 * muxes read data and ack back, and answers unmapped accesses itself
 */
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module bus_decoder (
	input  logic               clk48mhz_i,
	input  logic               sys_rst_i,
	input  logic               wb_cyc_i,
	input  logic               wb_stb_i,
	input  logic [`ADDR_W-1:0] wb_adr_i,
	output logic               ram_stb_o,
	input  logic [`DATA_W-1:0] ram_dat_i,
	input  logic               ram_ack_i,
	output logic               devtbl_stb_o,
	input  logic [`DATA_W-1:0] devtbl_dat_i,
	input  logic               devtbl_ack_i,
	output logic               intr_stb_o,
	input  logic [`DATA_W-1:0] intr_dat_i,
	input  logic               intr_ack_i,
	output logic [`DATA_W-1:0] wb_dat_o,
	output logic               wb_ack_o
);

	soc_pkg::slot_e slot;
	logic           req;
	logic           inv_ack_q;

	// Offset wraps around below the base, so one compare covers both ends
	function automatic logic in_region(
		input logic [`ADDR_W-1:0] adr,
		input logic [`ADDR_W-1:0] base,
		input logic [`ADDR_W-1:0] words
	);
		logic [`ADDR_W-1:0] ofs;
		ofs = adr - base;
		return (ofs < words);
	endfunction

	always_comb begin
		if (in_region(wb_adr_i, `ADDR_W'(`RAM_BASE), `ADDR_W'(`RAM_WORDS))) begin
			slot = soc_pkg::SLOT_RAM;
		end else if (in_region(wb_adr_i, `ADDR_W'(`DEVTBL_BASE),
				`ADDR_W'(`DEVTBL_WORDS))) begin
			slot = soc_pkg::SLOT_DEVTBL;
		end else if (in_region(wb_adr_i, `ADDR_W'(`INTCTRL_BASE),
				`ADDR_W'(`INTCTRL_WORDS))) begin
			slot = soc_pkg::SLOT_INTCTRL;
		end else begin
			slot = soc_pkg::SLOT_INVALID;
		end
	end

	assign req          = wb_cyc_i & wb_stb_i;
	assign ram_stb_o    = req & (slot == soc_pkg::SLOT_RAM);
	assign devtbl_stb_o = req & (slot == soc_pkg::SLOT_DEVTBL);
	assign intr_stb_o   = req & (slot == soc_pkg::SLOT_INTCTRL);

	// Invalid device, acks with zero data and drops writes
	always_ff @(posedge clk48mhz_i) begin
		if (sys_rst_i) begin
			inv_ack_q <= 1'b0;
		end else begin
			inv_ack_q <= req & (slot == soc_pkg::SLOT_INVALID) & ~inv_ack_q;
		end
	end

	// Master holds the address until ack, so the live decode picks the return path
	always_comb begin
		case (slot)
			soc_pkg::SLOT_RAM: begin
				wb_dat_o = ram_dat_i;
				wb_ack_o = ram_ack_i;
			end
			soc_pkg::SLOT_DEVTBL: begin
				wb_dat_o = devtbl_dat_i;
				wb_ack_o = devtbl_ack_i;
			end
			soc_pkg::SLOT_INTCTRL: begin
				wb_dat_o = intr_dat_i;
				wb_ack_o = intr_ack_i;
			end
			default: begin
				wb_dat_o = '0;
				wb_ack_o = inv_ack_q;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rst_sequencer.sv
/*
 * System reset sequencer. Counts the reset down after the button,
 * restarts it on software warm/cold reset and holds it on power-off
 */
`timescale 1ns/1ns
`default_nettype none

`include "soc_settings.svh"

module rst_sequencer (
	input  logic              clk48mhz_i,
	input  logic              rst_p,
	input  soc_pkg::rst_cmd_e rst_cmd_i,
	output logic              sys_rst_o
);

	soc_pkg::rst_state_e   state_q;
	logic [`RST_CNT_W-1:0] cnt_q;

	always_ff @(posedge clk48mhz_i) begin
		if (rst_p) begin
			state_q <= soc_pkg::RST_COUNT;
			cnt_q   <= `RST_CNT_W'(`RST_CYCLES);
		end else begin
			case (state_q)
				soc_pkg::RST_COUNT: begin
					// Last counted edge releases the system
					if (cnt_q == `RST_CNT_W'(1)) begin
						state_q <= soc_pkg::RST_RUN;
					end
					cnt_q <= cnt_q - `RST_CNT_W'(1);
				end
				soc_pkg::RST_RUN: begin
					case (rst_cmd_i)
						// No global cold reset here, both restart the count
						soc_pkg::RST_COLD,
						soc_pkg::RST_WARM: begin
							state_q <= soc_pkg::RST_COUNT;
							cnt_q   <= `RST_CNT_W'(`RST_CYCLES);
						end
						soc_pkg::RST_OFF: begin
							state_q <= soc_pkg::RST_HALT;
						end
						default: begin
							state_q <= soc_pkg::RST_RUN;
						end
					endcase
				end
				soc_pkg::RST_HALT: begin
					// Powered off, only the button brings it back
					state_q <= soc_pkg::RST_HALT;
				end
				default: begin
					state_q <= soc_pkg::RST_COUNT;
					cnt_q   <= `RST_CNT_W'(`RST_CYCLES);
				end
			endcase
		end
	end

	assign sys_rst_o = (state_q != soc_pkg::RST_RUN);

endmodule

`default_nettype wire

// File: soc_pkg.sv
/*
 * SoC fabric types: bus slots, reset commands and
 * reset sequencer states
 */
`default_nettype none

package soc_pkg;

	// Bus slot index, also the order of the device table
	typedef enum logic [1:0] {
		SLOT_RAM     = 2'd0,
		SLOT_DEVTBL  = 2'd1,
		SLOT_INTCTRL = 2'd2,
		SLOT_INVALID = 2'd3
	} slot_e;

	// Encoding follows the two reset control bits {bit1, bit0}
	typedef enum logic [1:0] {
		RST_NONE = 2'b00,
		RST_OFF  = 2'b01,
		RST_WARM = 2'b10,
		RST_COLD = 2'b11
	} rst_cmd_e;

	typedef enum logic [1:0] {
		RST_COUNT = 2'd0,
		RST_RUN   = 2'd1,
		RST_HALT  = 2'd2
	} rst_state_e;

endpackage

`default_nettype wire

// File: soc_settings.svh
/*
 * SoC fabric constants: bus widths, memory map, device ids,
 * reset length and interrupt source count
 */
`ifndef SOC_SETTINGS_SVH
`define SOC_SETTINGS_SVH

// Bus geometry, word addressed with byte selects
`define DATA_W 32
`define ADDR_W 30
`define SEL_W 4

// Counted system reset
`define RST_CYCLES 16
`define RST_CNT_W 5

`define SOC_ID 6

// Memory map in words
`define RAM_BASE 'h000
`define RAM_WORDS 1024
`define DEVTBL_BASE 'h400
`define DEVTBL_WORDS 16
`define INTCTRL_BASE 'h410
`define INTCTRL_WORDS 16
// Size reported for the catch-all slot
`define INVALID_WORDS 1024

// Device ids as reported by the device table
`define ID_RAM 1
`define ID_DEVTBL 7
`define ID_INTCTRL 3
`define ID_INVALID 0

`define INTR_SRC_COUNT 2

`endif
